/* hw/ps2_mouse_params.svh */
`ifndef PS2_MOUSE_PARAMS_SVH
`define PS2_MOUSE_PARAMS_SVH

// idle counter, timeout when top three bits are all ones (~1.1 ms @ 25 MHz)
`define PS2_TIMER_BITS 15

// clock filter depth in cycles
`define PS2_FILTER_LEN 6

// receive register, ack frame plus a 4-byte report
`define PS2_RX_BITS 42
// transmit register, start + data + parity
`define PS2_TX_BITS 10
// bits captured for one command, host frame tail + ack + response byte
`define PS2_ACK_BITS 21

// axis position widths
`define PS2_X_BITS 11
`define PS2_Y_BITS 11
`define PS2_Z_BITS 11

`endif

/* hw/ps2_mouse_pkg.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

package ps2_mouse_pkg;

  // absolute positions, two's complement, wrap on overflow
  typedef logic signed [`PS2_X_BITS-1:0] x_pos_t;
  typedef logic signed [`PS2_Y_BITS-1:0] y_pos_t;
  typedef logic signed [`PS2_Z_BITS-1:0] z_pos_t;

  typedef logic [8:0] init_cmd_t; // {odd parity, data byte}

  localparam int NUM_CMDS = 7;

  // enable reporting, then sample rate 200, 100, 80 to unlock the wheel
  localparam init_cmd_t INIT_CMDS [NUM_CMDS] = '{
    9'h0F4, // enable data reporting
    9'h1F3, // set sample rate
    9'h0C8, // 200
    9'h1F3,
    9'h064, // 100
    9'h1F3,
    9'h150  // 80
  };

  typedef enum logic [1:0] {
    RESET_WAIT, // idle after reset until first timeout
    REQUEST,    // host holds clock low
    TRANSFER,   // command bits out, ack frame in
    RUN         // streaming reports
  } seq_state_t;

endpackage

`default_nettype wire

/* hw/ps2_link_if.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

interface ps2_link_if;
  import ps2_mouse_pkg::*;

  logic                    req;      // clock-low request level
  init_cmd_t               cmd;      // current init command with parity
  logic                    run;      // init done, report mode
  logic                    done;     // one-cycle end-of-frame pulse
  logic [`PS2_RX_BITS-1:0] rx_frame; // receive shift register contents

  // sequencer side
  modport seq (
    output req, cmd, run,
    input  done
  );

  // shift register side
  modport shift (
    input  req, cmd, run,
    output done, rx_frame
  );

  // report decoder only listens
  modport mon (
    input done, run, rx_frame
  );

endinterface

`default_nettype wire

/* hw/ps2_line_timer.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

module ps2_line_timer (
  input  logic clk,
  input  logic arst_n,
  input  logic ps2_clk_in, // raw mouse clock, async
  input  logic req,        // host is pulling clock low
  output logic shift,      // filtered falling edge
  output logic timeout     // idle count reached
);

  logic [`PS2_FILTER_LEN-1:0] filter; // clock history, newest in bit 0
  logic [`PS2_TIMER_BITS-1:0] count;  // cycles since last edge or timeout

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      filter <= '1; // idle line is high
      count  <= '0;
    end else begin
      filter <= {filter[`PS2_FILTER_LEN-2:0], ps2_clk_in};
      count  <= (shift || timeout) ? '0 : count + 1'b1; // restart on activity
    end
  end

  // one high sample followed by a run of lows, glitches shorter than that are dropped
  // edges caused by our own clock-low request are ignored
  assign shift = !req && (filter == {1'b1, {(`PS2_FILTER_LEN-1){1'b0}}});

  assign timeout = &count[`PS2_TIMER_BITS-1 -: 3]; // top three bits set

  // a mouse frame never starts exactly on the idle timeout cycle
  a_shift_timeout_excl : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(shift && timeout)
  );

endmodule

`default_nettype wire

/* hw/ps2_init_sequencer.sv */
`default_nettype none

module ps2_init_sequencer (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    timeout,
  ps2_link_if.seq link
);
  import ps2_mouse_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  logic [2:0] sent;     // commands acknowledged so far
  logic       last_cmd; // current command is the final one

  assign last_cmd = (sent == 3'(NUM_CMDS - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      RESET_WAIT: if (timeout) state_nxt = REQUEST;  // let mouse finish its self test
      REQUEST:    if (timeout) state_nxt = TRANSFER; // clock held low long enough
      TRANSFER: begin
        // done only fires together with a timeout
        // without done the same command goes out again
        if (timeout) begin
          state_nxt = (link.done && last_cmd) ? RUN : REQUEST;
        end
      end
      default:    state_nxt = RUN; // stays in run
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= RESET_WAIT;
      sent  <= '0;
    end else begin
      state <= state_nxt;
      if (state == TRANSFER && link.done) sent <= sent + 1'b1; // ack frame taken
    end
  end

  assign link.req = (state == REQUEST);
  assign link.run = (state == RUN);
  assign link.cmd = (sent < 3'(NUM_CMDS)) ? INIT_CMDS[sent] : '1; // idle pattern once done

  // run is final and the clock is never requested again
  a_run_sticky : assert property (
    @(posedge clk) disable iff (!arst_n)
    link.run |=> link.run && !link.req
  );

  // shifter only reports a frame while a command is in flight
  a_done_in_transfer : assert property (
    @(posedge clk) disable iff (!arst_n)
    (link.done && !link.run) |-> (state == TRANSFER)
  );

endmodule

`default_nettype wire

/* hw/ps2_frame_shifter.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

module ps2_frame_shifter (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      shift,      // filtered falling clock edge
  input  logic      timeout,    // line idle
  input  logic      ps2_dat_in, // mouse data line
  ps2_link_if.shift link,
  output logic      tx_bit      // 0 pulls data low
);
  import ps2_mouse_pkg::*;

  // marker bit position once a command ack frame is complete
  localparam int ACK_POS = `PS2_RX_BITS - `PS2_ACK_BITS;

  logic [`PS2_TX_BITS-1:0] tx_reg; // lsb goes out first
  logic [`PS2_RX_BITS-1:0] rx_reg; // filled with ones and new bits enter at msb
  logic                    end_bit;
  seq_state_t              phase;  // link phase as seen from this side

  // the start bit (0) of the first byte acts as the end marker
  // when it arrives at its slot the frame is complete
  assign end_bit = link.run ? !rx_reg[0] : !rx_reg[ACK_POS];

  assign link.done     = end_bit && timeout && !link.req;
  assign link.rx_frame = rx_reg;
  assign tx_bit        = tx_reg[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_reg <= '1;
    end else if (link.run) begin
      tx_reg <= '1; // data line released for good
    end else if (link.req) begin
      tx_reg <= {link.cmd, 1'b0}; // start bit then command
    end else if (shift) begin
      tx_reg <= {1'b1, tx_reg[`PS2_TX_BITS-1:1]}; // ones fill in and release the stop bit
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_reg <= '1;
    end else if (link.done) begin
      rx_reg <= '1; // rearm the marker
    end else if (shift && !end_bit) begin
      rx_reg <= {ps2_dat_in, rx_reg[`PS2_RX_BITS-1:1]}; // trailing bits dropped
    end
  end

  assign phase = link.run ? RUN : (link.req ? REQUEST : TRANSFER);

  // the transmit register has shifted out by the last command and data stays released
  a_no_tx_in_run : assert property (
    @(posedge clk) disable iff (!arst_n)
    (phase == RUN) |-> tx_bit
  );

  // a new request only follows a completed frame and finds no stale receive bits
  a_rx_clear_on_req : assert property (
    @(posedge clk) disable iff (!arst_n)
    (phase == REQUEST) |-> &rx_reg
  );

endmodule

`default_nettype wire

/* hw/pos_accumulator.sv */
`default_nettype none

module pos_accumulator #(
  parameter type pos_t    = logic signed [7:0],
  parameter bit  subtract = 1'b0 // 1 for axes counted against the sensor
) (
  input  logic clk,
  input  logic arst_n,
  input  logic run,   // cleared outside run mode
  input  logic step,  // one report absorbed
  input  pos_t delta,
  output pos_t pos
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pos <= '0;
    end else if (!run) begin
      pos <= '0;
    end else if (step) begin
      pos <= subtract ? pos - delta : pos + delta; // wraps at type width
    end
  end

endmodule

`default_nettype wire

/* hw/ps2_report_decoder.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

module ps2_report_decoder (
  input  logic                   clk,
  input  logic                   arst_n,
  ps2_link_if.mon                link,
  output ps2_mouse_pkg::x_pos_t  x,
  output ps2_mouse_pkg::y_pos_t  y,
  output ps2_mouse_pkg::z_pos_t  z,
  output logic [2:0]             btn
);
  import ps2_mouse_pkg::*;

  logic [`PS2_RX_BITS-1:0] rx;
  x_pos_t dx;
  y_pos_t dy;
  z_pos_t dz;

  assign rx = link.rx_frame;

  // report bits: 3:1 buttons, 5/6 x/y sign, 7/8 x/y overflow
  // 19:12 x delta, 30:23 y delta, 37:34 wheel
  assign dx = {{(`PS2_X_BITS-8){rx[5]}}, rx[7] ? 8'h00 : rx[19:12]}; // overflow keeps sign only
  assign dy = {{(`PS2_Y_BITS-8){rx[6]}}, rx[8] ? 8'h00 : rx[30:23]};
  assign dz = {{(`PS2_Z_BITS-4){rx[37]}}, rx[37:34]}; // 4-bit signed wheel

  pos_accumulator #(.pos_t(x_pos_t), .subtract(1'b0)) i_acc_x (
    .clk, .arst_n, .run(link.run), .step(link.done), .delta(dx), .pos(x)
  );

  // mouse y is up-positive, screen y grows downwards
  pos_accumulator #(.pos_t(y_pos_t), .subtract(1'b1)) i_acc_y (
    .clk, .arst_n, .run(link.run), .step(link.done), .delta(dy), .pos(y)
  );

  pos_accumulator #(.pos_t(z_pos_t), .subtract(1'b0)) i_acc_z (
    .clk, .arst_n, .run(link.run), .step(link.done), .delta(dz), .pos(z)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) btn <= '0;
    else if (!link.run) btn <= '0;
    else if (link.done) btn <= rx[3:1]; // {middle, right, left}
  end

endmodule

`default_nettype wire

/* hw/ps2_mouse_top.sv */
`default_nettype none

module ps2_mouse_top (
  input  logic                  clk,
  input  logic                  arst_n,
  inout  wire                   ps2_clk, // open drain, external pullup
  inout  wire                   ps2_dat, // open drain, external pullup
  output ps2_mouse_pkg::x_pos_t x,
  output ps2_mouse_pkg::y_pos_t y,
  output ps2_mouse_pkg::z_pos_t z,
  output logic [2:0]            btn,
  output logic                  ready    // init finished, reports live
);

  logic shift;
  logic timeout;
  logic tx_bit;

  ps2_link_if link ();

  ps2_line_timer i_timer (
    .clk,
    .arst_n,
    .ps2_clk_in (ps2_clk),
    .req        (link.req),
    .shift,
    .timeout
  );

  ps2_init_sequencer i_seq (
    .clk,
    .arst_n,
    .timeout,
    .link (link.seq)
  );

  ps2_frame_shifter i_shift (
    .clk,
    .arst_n,
    .shift,
    .timeout,
    .ps2_dat_in (ps2_dat),
    .link       (link.shift),
    .tx_bit
  );

  ps2_report_decoder i_dec (
    .clk,
    .arst_n,
    .link (link.mon),
    .x,
    .y,
    .z,
    .btn
  );

  assign ps2_clk = link.req ? 1'b0 : 1'bz; // request to send
  assign ps2_dat = tx_bit ? 1'bz : 1'b0;   // only ever pulled low
  assign ready   = link.run;

endmodule

`default_nettype wire

/* tests/ps2_mouse_model.sv */
`default_nettype none

module ps2_mouse_model #(
  parameter int HALF        = 30, // ps2 clock half period in system cycles
  parameter int NUM_REPORTS = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  ready,        // host in run mode
  input  logic                  absorbed,     // host took the last report
  inout  wire                   ps2_clk,
  inout  wire                   ps2_dat,
  output int                    req_count,    // clock-low requests seen
  output int                    cmd_idx,
  output logic                  cmd_strobe,   // one cycle per received command
  output logic [10:0]           cmd_frame,    // {stop, parity, data, start}
  output logic                  all_acked,
  output logic                  clk_low,      // model pulls the clock low
  output logic                  dat_low,
  output ps2_mouse_pkg::x_pos_t exp_x,
  output ps2_mouse_pkg::y_pos_t exp_y,
  output ps2_mouse_pkg::z_pos_t exp_z,
  output logic [2:0]            exp_btn,
  output logic                  reports_done
);
  import ps2_mouse_pkg::*;

  logic [31:0] rnd;        // xorshift state
  logic        host_low;   // clock held low by the host
  logic        host_low_q;

  assign ps2_clk = clk_low ? 1'b0 : 1'bz;
  assign ps2_dat = dat_low ? 1'b0 : 1'bz;

  assign host_low = (ps2_clk === 1'b0) && !clk_low;

  // every start of a host clock-low period counts, whether or not a command follows
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_count  <= 0;
      host_low_q <= 1'b0;
    end else begin
      host_low_q <= host_low;
      if (host_low && !host_low_q) req_count <= req_count + 1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  // lands 2 time units after a rising system clock edge
  task automatic hold(input int cycles);
    repeat (cycles) @(posedge clk);
    #2;
  endtask

  task automatic clock_pulse();
    clk_low = 1'b1;
    hold(HALF);
    clk_low = 1'b0; // device samples on this rising edge
  endtask

  task automatic send_byte(input logic [7:0] data);
    logic [10:0] frame;
    frame = {1'b1, ~^data, data, 1'b0}; // start bit first with odd parity
    for (int i = 0; i < 11; i++) begin
      dat_low = !frame[i]; // data changes while clock is high
      hold(HALF);
      clock_pulse();
    end
    dat_low = 1'b0;
    hold(HALF);
  endtask

  task automatic take_command(input int n);
    logic [10:0] frame;
    wait (ps2_clk === 1'b0); // host inhibits and requests to send
    wait (ps2_clk === 1'b1);
    hold(2);
    frame[0] = ps2_dat; // start bit held by the host
    hold(2 * HALF);
    for (int i = 1; i < 11; i++) begin
      clock_pulse();
      frame[i] = ps2_dat;
      hold(HALF);
    end
    dat_low = 1'b1; // ack bit
    clock_pulse();
    hold(HALF);
    dat_low = 1'b0;
    cmd_idx    = n;
    cmd_frame  = frame;
    cmd_strobe = 1'b1;
    hold(1);
    cmd_strobe = 1'b0;
    hold(2 * HALF);
  endtask

  task automatic send_report(input int n);
    logic x_ovf;
    logic y_ovf;
    int   dx;
    int   dy;
    int   dz;
    rnd   = xorshift(rnd);
    x_ovf = (rnd[21:20] == 2'b00) || (n == 2); // forced once per axis
    y_ovf = (rnd[23:22] == 2'b00) || (n == 3);
    send_byte({y_ovf, x_ovf, rnd[17], rnd[16], 1'b1, rnd[26:24]});
    send_byte(rnd[7:0]);
    send_byte(rnd[15:8]);
    send_byte({{4{rnd[31]}}, rnd[31:28]}); // wheel sign extended to 8 bits
    dx = x_ovf ? 0 : int'(rnd[7:0]); // overflow drops the magnitude
    dy = y_ovf ? 0 : int'(rnd[15:8]);
    dz = int'(rnd[31:28]);
    if (rnd[16]) dx = dx - 256; // 9-bit two's complement
    if (rnd[17]) dy = dy - 256;
    if (rnd[31]) dz = dz - 16;
    exp_x   = x_pos_t'(int'(exp_x) + dx);
    exp_y   = y_pos_t'(int'(exp_y) - dy); // screen down is positive
    exp_z   = z_pos_t'(int'(exp_z) + dz);
    exp_btn = rnd[26:24];
  endtask

  initial begin
    rnd          = 32'd79673;
    cmd_idx      = 0;
    cmd_strobe   = 1'b0;
    cmd_frame    = '0;
    all_acked    = 1'b0;
    clk_low      = 1'b0;
    dat_low      = 1'b0;
    exp_x        = '0;
    exp_y        = '0;
    exp_z        = '0;
    exp_btn      = '0;
    reports_done = 1'b0;
    wait (arst_n === 1'b1);
    for (int n = 0; n < NUM_CMDS; n++) begin
      take_command(n);
      send_byte(8'hFA); // acknowledge
    end
    all_acked = 1'b1;
    wait (ready === 1'b1);
    hold(2 * HALF);
    for (int n = 0; n < NUM_REPORTS; n++) begin
      send_report(n);
      @(posedge clk iff absorbed);
      hold(2 * HALF);
    end
    reports_done = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/tb_ps2_mouse.sv */
`default_nettype none

`include "ps2_mouse_params.svh"

module tb_ps2_mouse;
  import ps2_mouse_pkg::*;

  localparam int HALF        = 30;
  localparam int NUM_REPORTS = 16;
  localparam int IDLE_CYCLES = (7 << (`PS2_TIMER_BITS - 3)) + 1; // one line timeout
  // one timeout after reset, two per command and one per report plus all frame clocks
  localparam longint LIMIT_CYCLES = longint'(1 + 2 * NUM_CMDS + NUM_REPORTS) * IDLE_CYCLES
    + NUM_CMDS * 26 * 2 * HALF + NUM_REPORTS * 50 * 2 * HALF;
  localparam logic [7:0] CMD_BYTES [7] = '{8'hF4, 8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50};

  logic        clk;
  logic        arst_n;
  wire         ps2_clk;
  wire         ps2_dat;
  x_pos_t      x;
  y_pos_t      y;
  z_pos_t      z;
  logic [2:0]  btn;
  logic        ready;
  logic        absorbed;
  int          req_count;
  int          cmd_idx;
  logic        cmd_strobe;
  logic [10:0] cmd_frame;
  logic        all_acked;
  logic        clk_low;
  logic        dat_low;
  x_pos_t      exp_x;
  y_pos_t      exp_y;
  z_pos_t      exp_z;
  logic [2:0]  exp_btn;
  logic        reports_done;
  int          errors = 0;
  int          absorbed_count = 0;

  pullup (ps2_clk);
  pullup (ps2_dat);

  ps2_mouse_top i_dut (
    .clk, .arst_n, .ps2_clk, .ps2_dat, .x, .y, .z, .btn, .ready
  );

  ps2_mouse_model #(.HALF(HALF), .NUM_REPORTS(NUM_REPORTS)) i_mouse (
    .clk, .arst_n, .ready, .absorbed, .ps2_clk, .ps2_dat, .req_count, .cmd_idx,
    .cmd_strobe, .cmd_frame, .all_acked, .clk_low, .dat_low,
    .exp_x, .exp_y, .exp_z, .exp_btn, .reports_done
  );

  assign absorbed = i_dut.link.done && ready; // report frame finished in run mode

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (absorbed) absorbed_count <= absorbed_count + 1;
  end

  a_init_zero : assert property (@(posedge clk) disable iff (!arst_n)
    !ready |-> x == '0 && y == '0 && z == '0 && btn == '0)
  else begin
    errors++;
    $display("Error init_zero: expected x=0 y=0 z=0 btn=000 actual x=%0d y=%0d z=%0d btn=%b",
      x, y, z, btn);
  end

  a_ready_late : assert property (@(posedge clk) disable iff (!arst_n) !all_acked |-> !ready)
  else begin
    errors++;
    $display("ready rose before the mouse had acknowledged all init commands");
  end

  a_cmd_byte : assert property (@(posedge clk) disable iff (!arst_n)
    cmd_strobe |-> cmd_frame[8:1] == CMD_BYTES[cmd_idx])
  else begin
    errors++;
    $display("Error init_cmd_%0d: expected %h actual %h", cmd_idx, CMD_BYTES[cmd_idx],
      cmd_frame[8:1]);
  end

  // start low and stop high with odd parity over data and parity bit
  a_cmd_frame : assert property (@(posedge clk) disable iff (!arst_n)
    cmd_strobe |-> !cmd_frame[0] && cmd_frame[10] && ^cmd_frame[9:1])
  else begin
    errors++;
    $display("init command %0d arrived with a bad start, stop or parity bit", cmd_idx);
  end

  a_cmd_request : assert property (@(posedge clk) disable iff (!arst_n)
    cmd_strobe |-> req_count == cmd_idx + 1)
  else begin
    errors++;
    $display("init command %0d did not follow exactly one clock-low request", cmd_idx);
  end

  a_run_clock : assert property (@(posedge clk) disable iff (!arst_n)
    ready && !clk_low |-> ps2_clk === 1'b1)
  else begin
    errors++;
    $display("host pulled the PS/2 clock low after init had finished");
  end

  a_run_data : assert property (@(posedge clk) disable iff (!arst_n)
    ready && !dat_low |-> ps2_dat === 1'b1)
  else begin
    errors++;
    $display("host pulled the PS/2 data line low after init had finished");
  end

  a_report : assert property (@(posedge clk) disable iff (!arst_n)
    absorbed |=> x == exp_x && y == exp_y && z == exp_z && btn == exp_btn)
  else begin
    errors++;
    $display("Error report_%0d: expected x=%0d y=%0d z=%0d btn=%b actual x=%0d y=%0d z=%0d btn=%b",
      absorbed_count, exp_x, exp_y, exp_z, exp_btn, x, y, z, btn);
  end

  task automatic print_counts();
    $display("errors: %0d, requests: %0d, reports absorbed: %0d", errors, req_count,
      absorbed_count);
  endtask

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    wait (reports_done === 1'b1);
    repeat (4) @(posedge clk);
    if (req_count != NUM_CMDS) begin
      errors++;
      $display("mouse saw %0d clock-low requests instead of seven", req_count);
    end
    if (absorbed_count != NUM_REPORTS) begin
      errors++;
      $display("host absorbed %0d reports, %0d were sent", absorbed_count, NUM_REPORTS);
    end
    print_counts();
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog allows twice the expected run length
  initial begin
    #(2 * LIMIT_CYCLES * 20);
    $display("watchdog expired, run did not finish within %0d cycles", 2 * LIMIT_CYCLES);
    print_counts();
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/ps2_mouse_pkg.sv
hw/ps2_link_if.sv
hw/ps2_line_timer.sv
hw/ps2_init_sequencer.sv
hw/ps2_frame_shifter.sv
hw/pos_accumulator.sv
hw/ps2_report_decoder.sv
hw/ps2_mouse_top.sv
tests/ps2_mouse_model.sv
tests/tb_ps2_mouse.sv
